// File: verilog.f
common/core_isa_pkg.sv
common/core_ctrl_pkg.sv
logic/fetch_unit.sv
execute/decode_unit.sv
execute/reg_file.sv
execute/exec_unit.sv
logic/retire_stage.sv
logic/rv_core.sv
testbench/core_chk.sv
testbench/core_monitor.sv
testbench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  # packages first, the rest of the design uses them
  - files:
      - common/core_isa_pkg.sv
      - common/core_ctrl_pkg.sv
      - logic/fetch_unit.sv
      - execute/decode_unit.sv
      - execute/reg_file.sv
      - execute/exec_unit.sv
      - logic/retire_stage.sv
      - logic/rv_core.sv

  # testbench, top module tb_rv_core
  - target: test
    files:
      - testbench/core_chk.sv
      - testbench/core_monitor.sv
      - testbench/tb_rv_core.sv

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 5;
    localparam int NUM_TESTS        = 5;
    localparam int RETIRES_PER_TEST = 200;
    // each test also spends its reset cycles plus one idle cycle out of reset
    localparam int MAX_CYCLES = NUM_TESTS * (RETIRES_PER_TEST + RESET_CYCLES + 1) + 100;

    logic                                clk;
    logic                                rst_n;
    logic [core_isa_pkg::ILEN-1:0]       imem_data;
    logic [core_isa_pkg::XLEN-1:0]       imem_addr;
    logic                                retire_valid;
    logic [core_isa_pkg::XLEN-1:0]       retire_pc;
    logic [core_isa_pkg::ILEN-1:0]       retire_inst;
    logic                                retire_we;
    logic [core_isa_pkg::REG_ADDR_W-1:0] retire_rd;
    logic [core_isa_pkg::XLEN-1:0]       retire_data;

    logic [core_isa_pkg::ILEN-1:0] prog [64];
    logic [31:0]                   rng_state;
    int                            retired;
    int                            mon_errors;
    int                            cycles = 0;
    int                            tests_passed = 0;
    int                            tests_failed = 0;

    rv_core UUT (
        .clk            (clk         ),
        .rst_n          (rst_n       ),
        .imem_data_i    (imem_data   ),
        .imem_addr_o    (imem_addr   ),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc   ),
        .retire_inst_o  (retire_inst ),
        .retire_we_o    (retire_we   ),
        .retire_rd_o    (retire_rd   ),
        .retire_data_o  (retire_data )
    );

    core_monitor u_monitor (
        .clk            (clk         ),
        .rst_n          (rst_n       ),
        .prog_i         (prog        ),
        .imem_addr_i    (imem_addr   ),
        .retire_valid_i (retire_valid),
        .retire_pc_i    (retire_pc   ),
        .retire_inst_i  (retire_inst ),
        .retire_we_i    (retire_we   ),
        .retire_rd_i    (retire_rd   ),
        .retire_data_i  (retire_data ),
        .retired_o      (retired     ),
        .errors_o       (mon_errors  )
    );

    bind rv_core core_chk u_chk (
        .clk            (clk           ),
        .rst_n          (rst_n         ),
        .imem_addr_i    (imem_addr_o   ),
        .retire_valid_i (retire_valid_o),
        .retire_pc_i    (retire_pc_o   ),
        .retire_we_i    (retire_we_o   ),
        .retire_rd_i    (retire_rd_o   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // instruction memory
    // ******************************
    function automatic int word_index(input logic [core_isa_pkg::XLEN-1:0] addr);
        return int'((addr - core_ctrl_pkg::RESET_PC) >> 2) & 63;
    endfunction

    // combinational read that wraps every 64 words
    assign imem_data = $isunknown(imem_addr) ? '0 : prog[word_index(imem_addr)];

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // up to 32 bytes either way and never zero
    function automatic int branch_offset();
        int steps;
        steps = int'(xorshift32() % 16) - 8;
        if (steps >= 0) begin
            steps++;
        end
        return steps * 4;
    endfunction

    function automatic logic [31:0] random_inst(input int mix);
        logic [31:0] r;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        int          kind;
        r     = xorshift32();
        rd    = r[4:0];
        rs1   = r[9:5];
        rs2   = r[14:10];
        imm12 = {{4{r[19]}}, r[19:12]};
        boff  = 13'(branch_offset());
        joff  = 21'(branch_offset());
        case (mix)
            0: kind = int'(r[31:20] % 6);
            1: begin
                // mostly negative addi with some lui and add
                kind      = (r[21:20] == 2'd3) ? 1 : ((r[21:20] == 2'd2) ? 6 : 0);
                imm12[11] = 1'b1;
            end
            2: begin
                kind = int'(r[31:20] % 5);
                kind = (kind == 0) ? 0 : ((kind == 4) ? 5 : kind + 6);
                // few registers so that beq finds equal values
                rd[4:2]  = 3'd0;
                rs1[4:2] = 3'd0;
                rs2[4:2] = 3'd0;
            end
            3: begin
                kind = (r[21:20] == 2'd0) ? 10 : int'(r[31:22] % 6);
                rd   = r[22] ? 5'd0 : rd;
                rs1  = r[23] ? 5'd0 : rs1;
                rs2  = r[24] ? 5'd0 : rs2;
            end
            default: kind = int'(r[31:20] % 11);
        endcase
        case (kind)
            0: inst = {imm12, rs1, core_isa_pkg::F3_ADD_SUB, rd, core_isa_pkg::OP_IMM};
            1: inst = {7'b0, rs2, rs1, core_isa_pkg::F3_ADD_SUB, rd, core_isa_pkg::OP_REG};
            2: inst = {core_isa_pkg::FUNCT7_SUB, rs2, rs1, core_isa_pkg::F3_ADD_SUB, rd,
                       core_isa_pkg::OP_REG};
            3: inst = {7'b0, rs2, rs1, core_isa_pkg::F3_AND, rd, core_isa_pkg::OP_REG};
            4: inst = {7'b0, rs2, rs1, core_isa_pkg::F3_OR, rd, core_isa_pkg::OP_REG};
            5: inst = {7'b0, rs2, rs1, core_isa_pkg::F3_XOR, rd, core_isa_pkg::OP_REG};
            6: inst = {r[31:12], rd, core_isa_pkg::OP_LUI};
            7: inst = {boff[12], boff[10:5], rs2, rs1, core_isa_pkg::F3_BEQ, boff[4:1],
                       boff[11], core_isa_pkg::OP_BRANCH};
            8: inst = {boff[12], boff[10:5], rs2, rs1, core_isa_pkg::F3_BNE, boff[4:1],
                       boff[11], core_isa_pkg::OP_BRANCH};
            9: inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, core_isa_pkg::OP_JAL};
            // load or system opcode outside the subset
            default: inst = {r[31:7], r[0] ? 7'b0000011 : 7'b1110011};
        endcase
        return inst;
    endfunction

    function automatic int total_errors();
        return mon_errors + UUT.u_chk.assert_errors;
    endfunction

    task automatic run_test(input int mix, input string name);
        int errors_before;
        int errors_seen;
        errors_before = total_errors();
        @(posedge clk);
        rst_n <= 1'b1;
        // new program goes in while the core sits in reset
        for (int i = 0; i < 64; i++) begin
            prog[i] <= random_inst(mix);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b0;
        while (retired < RETIRES_PER_TEST) begin
            @(posedge clk);
        end
        errors_seen = total_errors() - errors_before;
        if (errors_seen == 0) begin
            tests_passed++;
            $display("test %0d %s: PASS, %0d retired", mix + 1, name, retired);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d mismatches", mix + 1, name, errors_seen);
        end
    endtask

    initial begin
        rng_state = 32'd23073;
        rst_n <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            prog[i] <= '0;
        end
        run_test(0, "register ops");
        run_test(1, "immediates");
        run_test(2, "control flow");
        run_test(3, "x0 and unknown");
        run_test(4, "mixed");
        $display("tests: %0d passed, %0d failed, %0d mismatches in total",
                 tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: testbench/core_monitor.sv
`timescale 1ns/1ps

module core_monitor (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [core_isa_pkg::ILEN-1:0]       prog_i [64],
    input  logic [core_isa_pkg::XLEN-1:0]       imem_addr_i,
    input  logic                                retire_valid_i,
    input  logic [core_isa_pkg::XLEN-1:0]       retire_pc_i,
    input  logic [core_isa_pkg::ILEN-1:0]       retire_inst_i,
    input  logic                                retire_we_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] retire_rd_i,
    input  logic [core_isa_pkg::XLEN-1:0]       retire_data_i,
    output int                                  retired_o,
    output int                                  errors_o
);

    // reference state
    logic [63:0] model_pc;
    logic [63:0] model_regs [32];
    logic        in_reset;

    initial begin
        errors_o  = 0;
        retired_o = 0;
        in_reset  = 1'b1;
    end

    function automatic int word_index(input logic [63:0] pc);
        return int'((pc - core_ctrl_pkg::RESET_PC) >> 2) & 63;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED at time %0t: %s is %h, expected %h (pc %h)",
                 $time, what, got, exp, model_pc);
        errors_o++;
    endtask

    // ******************************
    // one retired instruction
    // ******************************
    task automatic check_retirement();
        logic [31:0] inst;
        logic [63:0] rs1_val;
        logic [63:0] rs2_val;
        logic [63:0] exp_data;
        logic [63:0] next_pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        exp_we;
        inst     = prog_i[word_index(model_pc)];
        rd       = inst[11:7];
        f3       = inst[14:12];
        rs1_val  = model_regs[inst[19:15]];
        rs2_val  = model_regs[inst[24:20]];
        exp_we   = 1'b0;
        exp_data = '0;
        next_pc  = model_pc + 64'd4;
        case (inst[6:0])
            // addi
            7'b0010011: begin
                exp_we   = (f3 == 3'b000);
                exp_data = rs1_val + {{52{inst[31]}}, inst[31:20]};
            end
            7'b0110011: begin
                exp_we = 1'b1;
                case ({inst[31:25], f3})
                    10'b0000000_000: exp_data = rs1_val + rs2_val;
                    10'b0100000_000: exp_data = rs1_val - rs2_val;
                    10'b0000000_100: exp_data = rs1_val ^ rs2_val;
                    10'b0000000_110: exp_data = rs1_val | rs2_val;
                    10'b0000000_111: exp_data = rs1_val & rs2_val;
                    default:         exp_we   = 1'b0;
                endcase
            end
            // lui
            7'b0110111: begin
                exp_we   = 1'b1;
                exp_data = {{32{inst[31]}}, inst[31:12], 12'b0};
            end
            // beq and bne with other funct3 values as no-ops
            7'b1100011: begin
                if ((f3 == 3'b000 && rs1_val == rs2_val) ||
                    (f3 == 3'b001 && rs1_val != rs2_val)) begin
                    next_pc = model_pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                                          inst[11:8], 1'b0};
                end
            end
            // jal
            7'b1101111: begin
                exp_we   = 1'b1;
                exp_data = model_pc + 64'd4;
                next_pc  = model_pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                       inst[30:21], 1'b0};
            end
            default: begin
                exp_we = 1'b0;
            end
        endcase
        if (rd == 5'd0) begin
            exp_we = 1'b0;
        end
        if (retire_pc_i !== model_pc) begin
            report_mismatch("retire_pc_o", retire_pc_i, model_pc);
        end
        if (retire_inst_i !== inst) begin
            report_mismatch("retire_inst_o", 64'(retire_inst_i), 64'(inst));
        end
        if (retire_we_i !== exp_we) begin
            report_mismatch("retire_we_o", 64'(retire_we_i), 64'(exp_we));
        end
        if (exp_we) begin
            if (retire_rd_i !== rd) begin
                report_mismatch("retire_rd_o", 64'(retire_rd_i), 64'(rd));
            end
            if (retire_data_i !== exp_data) begin
                report_mismatch("retire_data_o", retire_data_i, exp_data);
            end
            model_regs[rd] = exp_data;
        end
        model_pc = next_pc;
        retired_o++;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n !== 1'b0) begin
            model_pc = core_ctrl_pkg::RESET_PC;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            in_reset  = 1'b1;
            retired_o = 0;
        end else if (in_reset) begin
            // nothing retires in the first cycle out of reset
            in_reset = 1'b0;
            if (imem_addr_i !== core_ctrl_pkg::RESET_PC) begin
                report_mismatch("imem_addr_o", imem_addr_i, core_ctrl_pkg::RESET_PC);
            end
            if (retire_valid_i !== 1'b0 || retire_we_i !== 1'b0) begin
                report_mismatch("retire_valid_o", 64'(retire_valid_i), 64'd0);
            end
        end else if (retire_valid_i !== 1'b1) begin
            report_mismatch("retire_valid_o", 64'(retire_valid_i), 64'd1);
        end else begin
            check_retirement();
        end
    end

endmodule

// File: testbench/core_chk.sv
`timescale 1ns/1ps

module core_chk (
    input logic                                clk,
    input logic                                rst_n,
    input logic [core_isa_pkg::XLEN-1:0]       imem_addr_i,
    input logic                                retire_valid_i,
    input logic [core_isa_pkg::XLEN-1:0]       retire_pc_i,
    input logic                                retire_we_i,
    input logic [core_isa_pkg::REG_ADDR_W-1:0] retire_rd_i
);

    int assert_errors = 0;

    // x0 is never a write target
    write_has_rd: assert property (@(posedge clk) disable iff (rst_n)
        retire_we_i |-> retire_rd_i != '0)
        else begin
            $error("register write retired with rd equal to x0");
            assert_errors++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (rst_n)
        retire_valid_i |-> retire_pc_i[1:0] == 2'b00)
        else begin
            $error("retired pc is not word aligned");
            assert_errors++;
        end

    // one cycle from fetch address to retire
    pc_follows_fetch: assert property (@(posedge clk) disable iff (rst_n)
        retire_valid_i |-> retire_pc_i == $past(imem_addr_i))
        else begin
            $error("retired pc differs from the previous fetch address");
            assert_errors++;
        end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [core_isa_pkg::ILEN-1:0]       imem_data_i,
    output logic [core_isa_pkg::XLEN-1:0]       imem_addr_o,
    output logic                                retire_valid_o,
    output logic [core_isa_pkg::XLEN-1:0]       retire_pc_o,
    output logic [core_isa_pkg::ILEN-1:0]       retire_inst_o,
    output logic                                retire_we_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [core_isa_pkg::XLEN-1:0]       retire_data_o
);

    // fetch
    logic [core_isa_pkg::XLEN-1:0]       pc;
    logic [core_isa_pkg::ILEN-1:0]       inst;
    // decode and register file
    logic [core_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_isa_pkg::XLEN-1:0]       rs1_data;
    logic [core_isa_pkg::XLEN-1:0]       rs2_data;
    logic [core_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                                rd_we;
    core_ctrl_pkg::alu_op_e              alu_op;
    logic [core_isa_pkg::XLEN-1:0]       operand_a;
    logic [core_isa_pkg::XLEN-1:0]       operand_b;
    logic [core_isa_pkg::XLEN-1:0]       imm;
    core_ctrl_pkg::branch_e              branch;
    // execute
    logic [core_isa_pkg::XLEN-1:0]       wb_data;
    logic                                redirect;
    logic [core_isa_pkg::XLEN-1:0]       target;

    // ******************************
    // front end
    // ******************************
    fetch_unit u_fetch (
        .clk         (clk        ),
        .rst_n       (rst_n      ),
        .imem_data_i (imem_data_i),
        .redirect_i  (redirect   ),
        .target_i    (target     ),
        .imem_addr_o (imem_addr_o),
        .pc_o        (pc         ),
        .inst_o      (inst       )
    );

    decode_unit u_decode (
        .pc_i        (pc       ),
        .inst_i      (inst     ),
        .rs1_data_i  (rs1_data ),
        .rs2_data_i  (rs2_data ),
        .rs1_addr_o  (rs1_addr ),
        .rs2_addr_o  (rs2_addr ),
        .rd_o        (rd       ),
        .alu_op_o    (alu_op   ),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b),
        .imm_o       (imm      ),
        .branch_o    (branch   ),
        .rd_we_o     (rd_we    )
    );

    reg_file u_regs (
        .clk        (clk     ),
        .rst_n      (rst_n   ),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_i       (rd      ),
        .we_i       (rd_we   ),
        .wdata_i    (wb_data ),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_unit u_exec (
        .pc_i        (pc       ),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .imm_i       (imm      ),
        .alu_op_i    (alu_op   ),
        .branch_i    (branch   ),
        .wb_data_o   (wb_data  ),
        .redirect_o  (redirect ),
        .target_o    (target   )
    );

    // ******************************
    // trace and write-back outputs
    // ******************************
    retire_stage u_retire (
        .clk     (clk           ),
        .rst_n   (rst_n         ),
        .pc_i    (pc            ),
        .inst_i  (inst          ),
        .we_i    (rd_we         ),
        .rd_i    (rd            ),
        .data_i  (wb_data       ),
        .valid_o (retire_valid_o),
        .pc_o    (retire_pc_o   ),
        .inst_o  (retire_inst_o ),
        .we_o    (retire_we_o   ),
        .rd_o    (retire_rd_o   ),
        .data_o  (retire_data_o )
    );

endmodule

// File: logic/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [core_isa_pkg::XLEN-1:0]       pc_i,
    input  logic [core_isa_pkg::ILEN-1:0]       inst_i,
    input  logic                                we_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [core_isa_pkg::XLEN-1:0]       data_i,
    output logic                                valid_o,
    output logic [core_isa_pkg::XLEN-1:0]       pc_o,
    output logic [core_isa_pkg::ILEN-1:0]       inst_o,
    output logic                                we_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [core_isa_pkg::XLEN-1:0]       data_o
);

    // one instruction completes every cycle once out of reset
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else begin
            valid_o <= 1'b1;
            we_o    <= we_i;
        end
    end

    // trace payload
    always_ff @(posedge clk) begin
        pc_o   <= pc_i;
        inst_o <= inst_i;
        rd_o   <= rd_i;
        data_o <= data_i;
    end

endmodule

// File: execute/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic [core_isa_pkg::XLEN-1:0] pc_i,
    input  logic [core_isa_pkg::XLEN-1:0] operand_a_i,
    input  logic [core_isa_pkg::XLEN-1:0] operand_b_i,
    input  logic [core_isa_pkg::XLEN-1:0] imm_i,
    input  core_ctrl_pkg::alu_op_e        alu_op_i,
    input  core_ctrl_pkg::branch_e        branch_i,
    output logic [core_isa_pkg::XLEN-1:0] wb_data_o,
    output logic                          redirect_o,
    output logic [core_isa_pkg::XLEN-1:0] target_o
);

    logic [core_isa_pkg::XLEN-1:0] alu_result;
    logic                          operands_equal;

    // ******************************
    // alu
    // ******************************
    always_comb begin
        case (alu_op_i)
            core_ctrl_pkg::ALU_SUB:    alu_result = operand_a_i - operand_b_i;
            core_ctrl_pkg::ALU_AND:    alu_result = operand_a_i & operand_b_i;
            core_ctrl_pkg::ALU_OR:     alu_result = operand_a_i | operand_b_i;
            core_ctrl_pkg::ALU_XOR:    alu_result = operand_a_i ^ operand_b_i;
            core_ctrl_pkg::ALU_PASS_B: alu_result = operand_b_i;
            default:                   alu_result = operand_a_i + operand_b_i;
        endcase
    end

    // ******************************
    // branch and jump
    // ******************************
    assign operands_equal = (operand_a_i == operand_b_i);

    always_comb begin
        case (branch_i)
            core_ctrl_pkg::BR_EQ:  redirect_o = operands_equal;
            core_ctrl_pkg::BR_NE:  redirect_o = !operands_equal;
            core_ctrl_pkg::BR_JAL: redirect_o = 1'b1;
            default:               redirect_o = 1'b0;
        endcase
    end

    // both branches and jal are pc relative
    assign target_o = pc_i + imm_i;

    // jal links the return address
    assign wb_data_o = (branch_i == core_ctrl_pkg::BR_JAL) ?
                       pc_i + core_isa_pkg::INST_BYTES : alu_result;

endmodule

// File: execute/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [core_isa_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                                we_i,
    input  logic [core_isa_pkg::XLEN-1:0]       wdata_i,
    output logic [core_isa_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_isa_pkg::XLEN-1:0]       rs2_data_o
);

    // x1..x31, x0 has no storage
    logic [core_isa_pkg::XLEN-1:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // combinational reads, x0 reads zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: execute/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic [core_isa_pkg::XLEN-1:0]       pc_i,
    input  logic [core_isa_pkg::ILEN-1:0]       inst_i,
    input  logic [core_isa_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [core_isa_pkg::XLEN-1:0]       rs2_data_i,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [core_isa_pkg::REG_ADDR_W-1:0] rd_o,
    output core_ctrl_pkg::alu_op_e              alu_op_o,
    output logic [core_isa_pkg::XLEN-1:0]       operand_a_o,
    output logic [core_isa_pkg::XLEN-1:0]       operand_b_o,
    output logic [core_isa_pkg::XLEN-1:0]       imm_o,
    output core_ctrl_pkg::branch_e              branch_o,
    output logic                                rd_we_o
);

    core_isa_pkg::opcode_e         opcode;
    core_isa_pkg::funct3_e         funct3;
    logic [6:0]                    funct7;
    logic [core_isa_pkg::XLEN-1:0] imm_i_type;
    logic [core_isa_pkg::XLEN-1:0] imm_u_type;
    logic [core_isa_pkg::XLEN-1:0] imm_b_type;
    logic [core_isa_pkg::XLEN-1:0] imm_j_type;
    logic                          writes_rd;

    // ******************************
    // field extraction
    // ******************************
    assign opcode     = core_isa_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = core_isa_pkg::funct3_e'(inst_i[14:12]);
    assign funct7     = inst_i[31:25];
    assign rd_o       = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // sign extended immediates
    assign imm_i_type = {{(core_isa_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {{(core_isa_pkg::XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_b_type = {{(core_isa_pkg::XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_type = {{(core_isa_pkg::XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};

    // ******************************
    // control decode
    // ******************************
    always_comb begin
        writes_rd   = 1'b0;
        alu_op_o    = core_ctrl_pkg::ALU_ADD;
        operand_a_o = rs1_data_i;
        operand_b_o = rs2_data_i;
        imm_o       = imm_i_type;
        branch_o    = core_ctrl_pkg::BR_NONE;
        case (opcode)
            core_isa_pkg::OP_IMM: begin
                // only addi among the immediate ops
                writes_rd   = (funct3 == core_isa_pkg::F3_ADD_SUB);
                operand_b_o = imm_i_type;
            end
            core_isa_pkg::OP_REG: begin
                case (funct3)
                    core_isa_pkg::F3_ADD_SUB: begin
                        if (funct7 == core_isa_pkg::FUNCT7_SUB) begin
                            writes_rd = 1'b1;
                            alu_op_o  = core_ctrl_pkg::ALU_SUB;
                        end else begin
                            writes_rd = (funct7 == '0);
                        end
                    end
                    core_isa_pkg::F3_XOR: begin
                        writes_rd = (funct7 == '0);
                        alu_op_o  = core_ctrl_pkg::ALU_XOR;
                    end
                    core_isa_pkg::F3_OR: begin
                        writes_rd = (funct7 == '0);
                        alu_op_o  = core_ctrl_pkg::ALU_OR;
                    end
                    core_isa_pkg::F3_AND: begin
                        writes_rd = (funct7 == '0);
                        alu_op_o  = core_ctrl_pkg::ALU_AND;
                    end
                    default: begin
                        writes_rd = 1'b0;
                    end
                endcase
            end
            core_isa_pkg::OP_LUI: begin
                writes_rd   = 1'b1;
                alu_op_o    = core_ctrl_pkg::ALU_PASS_B;
                operand_b_o = imm_u_type;
                imm_o       = imm_u_type;
            end
            core_isa_pkg::OP_BRANCH: begin
                imm_o = imm_b_type;
                if (funct3 == core_isa_pkg::F3_BEQ) begin
                    branch_o = core_ctrl_pkg::BR_EQ;
                end else if (funct3 == core_isa_pkg::F3_BNE) begin
                    branch_o = core_ctrl_pkg::BR_NE;
                end
            end
            core_isa_pkg::OP_JAL: begin
                // link value is built in execute, operand a only kept defined
                writes_rd   = 1'b1;
                operand_a_o = pc_i;
                imm_o       = imm_j_type;
                branch_o    = core_ctrl_pkg::BR_JAL;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // x0 destination never writes
    assign rd_we_o = writes_rd && (rd_o != '0);

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [core_isa_pkg::ILEN-1:0] imem_data_i,
    input  logic                          redirect_i,
    input  logic [core_isa_pkg::XLEN-1:0] target_i,
    output logic [core_isa_pkg::XLEN-1:0] imem_addr_o,
    output logic [core_isa_pkg::XLEN-1:0] pc_o,
    output logic [core_isa_pkg::ILEN-1:0] inst_o
);

    logic [core_isa_pkg::XLEN-1:0] pc_q;
    logic [core_isa_pkg::XLEN-1:0] pc_next;

    // taken branch or jal wins over the sequential step
    assign pc_next = redirect_i ? target_i : pc_q + core_isa_pkg::INST_BYTES;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= core_ctrl_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // memory answers in the same cycle
    assign imem_addr_o = pc_q;
    assign pc_o        = pc_q;
    assign inst_o      = imem_data_i;

endmodule

// File: common/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // ******************************
    // internal control encodings
    // ******************************

    // alu operation picked by the decoder
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // lui result is operand b as is
        ALU_PASS_B
    } alu_op_e;

    // control flow kind
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } branch_e;

    // first fetch address after reset
    localparam logic [core_isa_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

endpackage

// File: common/core_isa_pkg.sv
package core_isa_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // pc stride between sequential instructions
    localparam logic [XLEN-1:0] INST_BYTES = 4;

    // ******************************
    // major opcodes of the kept subset
    // ******************************
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // funct3 values in use
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_BNE     = 3'b001,
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // beq shares its encoding with add/sub, so it is an alias
    localparam funct3_e F3_BEQ = F3_ADD_SUB;

    // funct7 that turns add into sub
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

endpackage
